// File: src/mips_pipe_config.svh
`ifndef MIPS_PIPE_CONFIG_SVH
`define MIPS_PIPE_CONFIG_SVH

// first fetch address
`define MIPS_RESET_PC 32'h0000_0000

// data path and address width
`define MIPS_XLEN 32

`define MIPS_REG_COUNT 32

// data memory depth in words
`define MIPS_DMEM_WORDS 256

`endif

// File: src/mips_pkg.sv
`include "mips_pipe_config.svh"

package mips_pkg;

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addiu = 6'h09,
        op_lui   = 6'h0f,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_sll,
        alu_lui
    } alu_op_e;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    // one word, two views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    use_imm;
        logic    use_shamt;
        logic    mem_to_reg;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [`MIPS_XLEN-1:0] pc_4;
        instr_u                instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [4:0]            rs;
        logic [4:0]            rt;
        logic [`MIPS_XLEN-1:0] rs_val;
        logic [`MIPS_XLEN-1:0] rt_val;
        logic [`MIPS_XLEN-1:0] imm;
        logic [4:0]            shamt;
        logic [4:0]            dest;
    } id_ex_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic                  mem_to_reg;
        logic [`MIPS_XLEN-1:0] alu_result;
        logic [`MIPS_XLEN-1:0] store_data;
        logic [4:0]            dest;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_to_reg;
        logic [`MIPS_XLEN-1:0] alu_result;
        logic [`MIPS_XLEN-1:0] load_data;
        logic [4:0]            dest;
    } mem_wb_t;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0] addr;
        logic [`MIPS_XLEN-1:0] wdata;
        logic                  write;
        logic                  read;
    } dmem_req_t;

    // bypass offer from a later stage
    typedef struct packed {
        logic                  reg_write;
        logic [4:0]            dest;
        logic [`MIPS_XLEN-1:0] value;
    } fwd_t;

endpackage

// File: src/fetch_stage.sv
`timescale 1ns/1ps
`include "mips_pipe_config.svh"

module fetch_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_en,
    input  logic                   stall,
    input  logic                   redirect,
    input  logic [`MIPS_XLEN-1:0]  target,
    input  logic [`MIPS_XLEN-1:0]  instruction_in,
    output logic [`MIPS_XLEN-1:0]  pc,
    output mips_pkg::if_id_t       if_id
);

    logic [`MIPS_XLEN-1:0] pc_4;

    assign pc_4 = pc + `MIPS_XLEN'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= `MIPS_RESET_PC;
            if_id.valid <= 1'b0;
        end else if (cpu_en) begin
            if (redirect) begin
                // wrong-path word is dropped
                pc          <= target;
                if_id.valid <= 1'b0;
            end else if (!stall) begin
                pc          <= pc_4;
                if_id.valid <= 1'b1;
                if_id.pc_4  <= pc_4;
                if_id.instr <= instruction_in;
            end
        end
    end

    // targets from decode keep word alignment
    pc_aligned: assert property (
        @(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00
    );

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps
`include "mips_pipe_config.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_en,
    input  mips_pkg::if_id_t       if_id,
    input  mips_pkg::fwd_t         wb_fwd,
    input  mips_pkg::fwd_t         mem_fwd,
    input  mips_pkg::fwd_t         ex_hazard,
    output mips_pkg::id_ex_t       id_ex,
    output logic                   stall,
    output logic                   redirect,
    output logic [`MIPS_XLEN-1:0]  target
);

    localparam logic [5:0] funct_sll  = 6'h00;
    localparam logic [5:0] funct_addu = 6'h21;
    localparam logic [5:0] funct_subu = 6'h23;
    localparam logic [5:0] funct_and  = 6'h24;
    localparam logic [5:0] funct_or   = 6'h25;
    localparam logic [5:0] funct_slt  = 6'h2a;

    logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];
    mips_pkg::instr_u      instr;
    mips_pkg::opcode_e     opcode;
    mips_pkg::ctrl_t       ctrl;
    logic [4:0]            rs;
    logic [4:0]            rt;
    logic [4:0]            dest;
    logic [`MIPS_XLEN-1:0] imm_ext;
    logic [`MIPS_XLEN-1:0] rs_val;
    logic [`MIPS_XLEN-1:0] rt_val;
    logic [`MIPS_XLEN-1:0] br_a;
    logic [`MIPS_XLEN-1:0] br_b;
    logic                  uses_rs;
    logic                  uses_rt;
    logic                  is_branch;
    logic                  taken;
    logic                  ex_load_hit;
    logic                  ex_write_hit;
    logic                  mem_load_hit;
    logic                  mem_load_valid;
    logic [4:0]            mem_load_dest;

    assign instr  = if_id.instr;
    assign opcode = mips_pkg::opcode_e'(instr.r.opcode);
    assign rs     = instr.i.rs;
    assign rt     = instr.i.rt;

    // write-before-read through the wb bypass
    assign rs_val = (rs == 5'd0) ? '0 :
                    (wb_fwd.reg_write && wb_fwd.dest == rs) ? wb_fwd.value : regs[rs];
    assign rt_val = (rt == 5'd0) ? '0 :
                    (wb_fwd.reg_write && wb_fwd.dest == rt) ? wb_fwd.value : regs[rt];

    always_ff @(posedge clk) begin
        if (cpu_en && wb_fwd.reg_write) begin
            regs[wb_fwd.dest] <= wb_fwd.value;
        end
    end

    always_comb begin
        ctrl      = '0;
        dest      = instr.r.rd;
        imm_ext   = {{16{instr.i.imm16[15]}}, instr.i.imm16};
        uses_rs   = 1'b1;
        uses_rt   = 1'b0;
        is_branch = 1'b0;
        case (opcode)
            mips_pkg::op_rtype: begin
                ctrl.reg_write = 1'b1;
                uses_rt        = 1'b1;
                case (instr.r.funct)
                    funct_addu: ctrl.alu_op = mips_pkg::alu_add;
                    funct_subu: ctrl.alu_op = mips_pkg::alu_sub;
                    funct_and:  ctrl.alu_op = mips_pkg::alu_and;
                    funct_or:   ctrl.alu_op = mips_pkg::alu_or;
                    funct_slt:  ctrl.alu_op = mips_pkg::alu_slt;
                    funct_sll: begin
                        ctrl.alu_op    = mips_pkg::alu_sll;
                        ctrl.use_shamt = 1'b1;
                        uses_rs        = 1'b0;
                    end
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            mips_pkg::op_addiu: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                dest           = rt;
            end
            mips_pkg::op_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = mips_pkg::alu_lui;
                dest           = rt;
                imm_ext        = {16'b0, instr.i.imm16};
                uses_rs        = 1'b0;
            end
            mips_pkg::op_lw: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.use_imm    = 1'b1;
                dest            = rt;
            end
            mips_pkg::op_sw: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                uses_rt        = 1'b1;
            end
            mips_pkg::op_beq, mips_pkg::op_bne: begin
                is_branch = 1'b1;
                uses_rt   = 1'b1;
            end
            default: uses_rs = 1'b0;
        endcase
        // r0 is never written
        if (dest == 5'd0) begin
            ctrl.reg_write = 1'b0;
        end
        if (!if_id.valid) begin
            ctrl = '0;
        end
    end

    // load in EX last cycle, now in MEM
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_load_valid <= 1'b0;
        end else if (cpu_en) begin
            mem_load_valid <= ex_hazard.reg_write && ex_hazard.dest != 5'd0;
            mem_load_dest  <= ex_hazard.dest;
        end
    end

    assign ex_load_hit  = ex_hazard.reg_write && ex_hazard.dest != 5'd0 &&
                          ((uses_rs && ex_hazard.dest == rs) ||
                           (uses_rt && ex_hazard.dest == rt));
    assign ex_write_hit = is_branch && id_ex.ctrl.reg_write &&
                          (id_ex.dest == rs || id_ex.dest == rt);
    assign mem_load_hit = is_branch && mem_load_valid &&
                          (mem_load_dest == rs || mem_load_dest == rt);
    assign stall        = if_id.valid && (ex_load_hit || ex_write_hit || mem_load_hit);

    // branch operands, MEM result before the register file
    assign br_a = (mem_fwd.reg_write && mem_fwd.dest == rs) ? mem_fwd.value : rs_val;
    assign br_b = (mem_fwd.reg_write && mem_fwd.dest == rt) ? mem_fwd.value : rt_val;

    always_comb begin
        case (opcode)
            mips_pkg::op_beq: taken = (br_a == br_b);
            mips_pkg::op_bne: taken = (br_a != br_b);
            mips_pkg::op_j:   taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    assign redirect = if_id.valid && !stall && taken;
    assign target   = (opcode == mips_pkg::op_j) ?
                      {if_id.pc_4[31:28], instr.i.rs, instr.i.rt, instr.i.imm16, 2'b00} :
                      if_id.pc_4 + {imm_ext[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.ctrl <= '0;
        end else if (cpu_en) begin
            id_ex.ctrl   <= stall ? '0 : ctrl;
            id_ex.rs     <= rs;
            id_ex.rt     <= rt;
            id_ex.rs_val <= rs_val;
            id_ex.rt_val <= rt_val;
            id_ex.imm    <= imm_ext;
            id_ex.shamt  <= instr.r.shamt;
            id_ex.dest   <= dest;
        end
    end

    // a stalled instruction waits in IF/ID
    stall_holds_if_id: assert property (
        @(posedge clk) disable iff (rst)
        (cpu_en && stall) |=> $stable(if_id)
    );

endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ps
`include "mips_pipe_config.svh"

module execute_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cpu_en,
    input  mips_pkg::id_ex_t     id_ex,
    input  mips_pkg::fwd_t       wb_fwd,
    output mips_pkg::ex_mem_t    ex_mem,
    output mips_pkg::fwd_t       mem_fwd,
    output mips_pkg::fwd_t       ex_hazard,
    output mips_pkg::dmem_req_t  dmem
);

    logic [`MIPS_XLEN-1:0] fwd_a;
    logic [`MIPS_XLEN-1:0] fwd_b;
    logic [`MIPS_XLEN-1:0] op_a;
    logic [`MIPS_XLEN-1:0] op_b;
    logic [`MIPS_XLEN-1:0] result;

    // MEM wins over WB
    assign fwd_a = (mem_fwd.reg_write && mem_fwd.dest == id_ex.rs) ? mem_fwd.value :
                   (wb_fwd.reg_write && wb_fwd.dest == id_ex.rs) ? wb_fwd.value : id_ex.rs_val;
    assign fwd_b = (mem_fwd.reg_write && mem_fwd.dest == id_ex.rt) ? mem_fwd.value :
                   (wb_fwd.reg_write && wb_fwd.dest == id_ex.rt) ? wb_fwd.value : id_ex.rt_val;

    assign op_a = id_ex.ctrl.use_shamt ? {27'b0, id_ex.shamt} : fwd_a;
    assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : fwd_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            mips_pkg::alu_add: result = op_a + op_b;
            mips_pkg::alu_sub: result = op_a - op_b;
            mips_pkg::alu_and: result = op_a & op_b;
            mips_pkg::alu_or:  result = op_a | op_b;
            mips_pkg::alu_slt: result = {31'b0, $signed(op_a) < $signed(op_b)};
            mips_pkg::alu_sll: result = op_b << op_a[4:0];
            mips_pkg::alu_lui: result = {op_b[15:0], 16'b0};
            default:           result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.reg_write  <= 1'b0;
            ex_mem.mem_read   <= 1'b0;
            ex_mem.mem_write  <= 1'b0;
            ex_mem.mem_to_reg <= 1'b0;
        end else if (cpu_en) begin
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.mem_read   <= id_ex.ctrl.mem_read;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
            ex_mem.alu_result <= result;
            ex_mem.store_data <= fwd_b;
            ex_mem.dest       <= id_ex.dest;
        end
    end

    assign dmem = '{addr:  ex_mem.alu_result,
                    wdata: ex_mem.store_data,
                    write: ex_mem.mem_write,
                    read:  ex_mem.mem_read};

    // load data is not ready until WB
    assign mem_fwd   = '{reg_write: ex_mem.reg_write && !ex_mem.mem_read,
                         dest:      ex_mem.dest,
                         value:     ex_mem.alu_result};
    assign ex_hazard = '{reg_write: id_ex.ctrl.mem_read, dest: id_ex.dest, value: '0};

    dmem_one_op: assert property (
        @(posedge clk) disable iff (rst)
        !(dmem.write && dmem.read)
    );

endmodule

// File: src/writeback_stage.sv
`timescale 1ns/1ps
`include "mips_pipe_config.svh"

module writeback_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_en,
    input  mips_pkg::ex_mem_t      ex_mem,
    input  logic [`MIPS_XLEN-1:0]  data_in,
    output mips_pkg::fwd_t         wb_fwd
);

    mips_pkg::mem_wb_t mem_wb;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb.reg_write <= 1'b0;
        end else if (cpu_en) begin
            mem_wb.reg_write  <= ex_mem.reg_write;
            mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.load_data  <= data_in;
            mem_wb.dest       <= ex_mem.dest;
        end
    end

    assign wb_fwd = '{reg_write: mem_wb.reg_write,
                      dest:      mem_wb.dest,
                      value:     mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result};

    // decode drops writes to r0
    no_r0_write: assert property (
        @(posedge clk) disable iff (rst)
        !(wb_fwd.reg_write && wb_fwd.dest == 5'd0)
    );

endmodule

// File: src/mips_pipe_top.sv
`timescale 1ns/1ps
`include "mips_pipe_config.svh"

module mips_pipe_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_en,
    input  logic [`MIPS_XLEN-1:0]  instruction_in,
    input  logic [`MIPS_XLEN-1:0]  data_in,
    output logic [`MIPS_XLEN-1:0]  pc,
    output mips_pkg::dmem_req_t    dmem
);

    mips_pkg::if_id_t      if_id;
    mips_pkg::id_ex_t      id_ex;
    mips_pkg::ex_mem_t     ex_mem;
    mips_pkg::fwd_t        wb_fwd;
    mips_pkg::fwd_t        mem_fwd;
    mips_pkg::fwd_t        ex_hazard;
    logic                  stall;
    logic                  redirect;
    logic [`MIPS_XLEN-1:0] target;

    fetch_stage u_fetch (
        .clk            (clk),
        .rst            (rst),
        .cpu_en         (cpu_en),
        .stall          (stall),
        .redirect       (redirect),
        .target         (target),
        .instruction_in (instruction_in),
        .pc             (pc),
        .if_id          (if_id)
    );

    decode_stage u_decode (
        .clk       (clk),
        .rst       (rst),
        .cpu_en    (cpu_en),
        .if_id     (if_id),
        .wb_fwd    (wb_fwd),
        .mem_fwd   (mem_fwd),
        .ex_hazard (ex_hazard),
        .id_ex     (id_ex),
        .stall     (stall),
        .redirect  (redirect),
        .target    (target)
    );

    execute_stage u_execute (
        .clk       (clk),
        .rst       (rst),
        .cpu_en    (cpu_en),
        .id_ex     (id_ex),
        .wb_fwd    (wb_fwd),
        .ex_mem    (ex_mem),
        .mem_fwd   (mem_fwd),
        .ex_hazard (ex_hazard),
        .dmem      (dmem)
    );

    writeback_stage u_writeback (
        .clk     (clk),
        .rst     (rst),
        .cpu_en  (cpu_en),
        .ex_mem  (ex_mem),
        .data_in (data_in),
        .wb_fwd  (wb_fwd)
    );

endmodule

// File: testbench/tb_mips_pipe.sv
`timescale 1ns/1ps
`include "mips_pipe_config.svh"

module tb_mips_pipe;

    localparam int imem_words = 64;
    localparam int dmem_aw    = $clog2(`MIPS_DMEM_WORDS);
    localparam int idle_edges = 20;

    logic                  clk;
    logic                  rst;
    logic                  cpu_en;
    logic [`MIPS_XLEN-1:0] instruction_in;
    logic [`MIPS_XLEN-1:0] data_in;
    logic [`MIPS_XLEN-1:0] pc;
    mips_pkg::dmem_req_t   dmem;

    logic [31:0] imem     [imem_words];
    logic [31:0] dmem_mem [`MIPS_DMEM_WORDS];
    logic [31:0] init_addr[$];
    logic [31:0] init_data[$];
    logic [31:0] exp_addr[$];
    logic [31:0] exp_data[$];
    int          n_stores;
    int          store_idx;
    logic        loaded;
    logic [31:0] rand_state;

    mips_pipe_top u_dut (
        .clk            (clk),
        .rst            (rst),
        .cpu_en         (cpu_en),
        .instruction_in (instruction_in),
        .data_in        (data_in),
        .pc             (pc),
        .dmem           (dmem)
    );

    // both memories answer in the same cycle, data only on a read
    assign instruction_in = imem[pc[2 +: 6]];
    assign data_in        = dmem.read ? dmem_mem[dmem.addr[2 +: dmem_aw]] : '0;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h",
                                        name, actual, expected));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          code;
        int          n_words;
        logic [7:0]  tag;
        logic [31:0] a;
        logic [31:0] d;
        logic [1023:0] comment;
        n_words = 0;
        for (int i = 0; i < imem_words; i++) begin
            imem[6'(i)] = '0;
        end
        fd = $fopen("testbench/mips_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open testbench/mips_stimulus.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break;
            end
            case (tag)
                "I": begin
                    code = $fscanf(fd, "%h", d);
                    imem[6'(n_words)] = d;
                    n_words++;
                end
                "D": begin
                    code = $fscanf(fd, "%h %h", a, d);
                    init_addr.push_back(a);
                    init_data.push_back(d);
                end
                "S": begin
                    code = $fscanf(fd, "%h %h", a, d);
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                end
                "#": code = $fgets(comment, fd);
                default: stop_with_failure("stimulus file holds an unknown record type");
            endcase
        end
        $fclose(fd);
        n_stores = exp_addr.size();
        if (n_words == 0 || n_stores == 0) begin
            stop_with_failure("stimulus file has no program or no expected stores");
        end
    endtask

    // each observed store must be the next expected one
    always @(posedge clk) begin
        if (!rst && cpu_en && dmem.write) begin
            if (store_idx >= n_stores) begin
                stop_with_failure($sformatf("store to 0x%08h after the last expected store",
                                            dmem.addr));
            end else begin
                check_equal("dmem.addr", dmem.addr, exp_addr[store_idx]);
                check_equal("dmem.wdata", dmem.wdata, exp_data[store_idx]);
                dmem_mem[dmem.addr[2 +: dmem_aw]] = dmem.wdata;
                store_idx = store_idx + 1;
            end
        end
    end

    task automatic run_pass(input logic random_en);
        int          idle_count;
        logic        done_before;
        logic [31:0] held_pc;
        rst       = 1'b1;
        cpu_en    = 1'b0;
        store_idx = 0;
        for (int i = 0; i < `MIPS_DMEM_WORDS; i++) begin
            dmem_mem[dmem_aw'(i)] = ~(32'(i) << 2);
        end
        foreach (init_addr[k]) begin
            dmem_mem[init_addr[k][2 +: dmem_aw]] = init_data[k];
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_equal("pc", pc, `MIPS_RESET_PC);
        check_equal("dmem.write", 32'(dmem.write), 32'h0);
        check_equal("dmem.read", 32'(dmem.read), 32'h0);
        idle_count = 0;
        while (store_idx < n_stores || idle_count < idle_edges) begin
            held_pc     = pc;
            done_before = (store_idx == n_stores);
            if (random_en) begin
                rand_state = xorshift32(rand_state);
                cpu_en     = (rand_state[1:0] != 2'b00);
            end else begin
                cpu_en = 1'b1;
            end
            @(negedge clk);
            // program has no load before its first store
            if (store_idx == 0) begin
                check_equal("dmem.read", 32'(dmem.read), 32'h0);
            end
            if (!cpu_en) begin
                check_equal("pc", pc, held_pc);
            end else if (done_before) begin
                idle_count++;
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        cpu_en     = 1'b0;
        loaded     = 1'b0;
        store_idx  = 0;
        n_stores   = 0;
        rand_state = 32'h0353_6884;
        load_stimulus();
        loaded = 1'b1;
        run_pass(1'b0);
        // same program again with a frozen pipeline now and then
        run_pass(1'b1);
        if (store_idx == n_stores) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_with_failure("store sequence incomplete at the end of the run");
        end
    end

    initial begin
        wait (loaded);
        #(n_stores * 40 * 2 * 8);
        stop_with_failure("timeout, the expected stores did not all appear in time");
    end

endmodule

// File: mips_pipe.f
+incdir+src
src/mips_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/writeback_stage.sv
src/mips_pipe_top.sv
testbench/tb_mips_pipe.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, pass only when the log holds the pass message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_mips_pipe -f mips_pipe.f \
    && ./obj_dir/Vtb_mips_pipe > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -q "All tests passed!" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// File: testbench/mips_stimulus.txt
# I word (program from address 0) | D byte_addr data (initial data memory)
# S byte_addr data (expected stores, in program order)
D 00000080 00000011
D 00000084 00000005
D 00000088 00000011
I 3C011234  # lui   $1, 0x1234
I 24215678  # addiu $1, $1, 0x5678
I 24020F0F  # addiu $2, $0, 0x0f0f
I 00221821  # addu  $3, $1, $2
I 00412023  # subu  $4, $2, $1
I 00822824  # and   $5, $4, $2
I 00A13025  # or    $6, $5, $1
I 0082382A  # slt   $7, $4, $2
I 00064100  # sll   $8, $6, 4
I AC030000  # sw    $3, 0x00($0)
I AC040004  # sw    $4, 0x04($0)
I AC050008  # sw    $5, 0x08($0)
I AC06000C  # sw    $6, 0x0c($0)
I AC070010  # sw    $7, 0x10($0)
I AC080014  # sw    $8, 0x14($0)
I 8C090080  # lw    $9, 0x80($0)
I 01215021  # addu  $10, $9, $1   load-use
I AC0A0018  # sw    $10, 0x18($0)
I 8C0B0084  # lw    $11, 0x84($0)
I AC0B001C  # sw    $11, 0x1c($0)   load-use on store data
I 8C0C0088  # lw    $12, 0x88($0)
I 11890001  # beq   $12, $9, +1   taken, operand from load
I AC010040  # sw    $1, 0x40($0)   skipped
I 152B0001  # bne   $9, $11, +1   taken
I AC020044  # sw    $2, 0x44($0)   skipped
I 112B0001  # beq   $9, $11, +1   not taken
I AC090020  # sw    $9, 0x20($0)
I 152C0001  # bne   $9, $12, +1   not taken
I AC0B0024  # sw    $11, 0x24($0)
I 0800001F  # j     0x7c
I AC030048  # sw    $3, 0x48($0)   skipped
I 256D0002  # addiu $13, $11, 2
I 15AB0001  # bne   $13, $11, +1   taken, operand from ALU
I AC01004C  # sw    $1, 0x4c($0)   skipped
I AC0D0028  # sw    $13, 0x28($0)
I 08000023  # j     0x8c   self-loop
S 00000000 12346587
S 00000004 EDCBB897
S 00000008 00000807
S 0000000C 12345E7F
S 00000010 00000001
S 00000014 2345E7F0
S 00000018 12345689
S 0000001C 00000005
S 00000020 00000011
S 00000024 00000005
S 00000028 00000007
